//--- Makefile
# Verilator build and run for the AXI register slice testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module axi_mem_reg_tb \
		-Mdir obj_dir -f axi_reg.f
	./obj_dir/Vaxi_mem_reg_tb > sim.log 2>&1; status=$$?; cat sim.log; \
		if [ $$status -ne 0 ] || grep -q "Simulation failed" sim.log; then \
			exit 1; \
		fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- axi_reg.f
src/axi_reg_pkg.sv
src/axi_mem_if.sv
src/ready_enable_reg.sv
src/axi_mem_reg_stages.sv
src/axi_mem_slave.sv
src/axi_mem_reg_top.sv
bench/axi_mem_reg_assert.sv
bench/axi_mem_reg_tb.sv

//--- bench/axi_mem_golden.txt
# op addr wdata resp rdata, all hex; op W is a write and R is a read
# Writes expect only resp, reads expect resp and rdata
W 00 11110000 0 00000000
W 01 22220001 0 00000000
W 02 33330002 0 00000000
W 07 44440007 0 00000000
W 10 55550010 0 00000000
W 2a 6666002a 0 00000000
W 3e 7777003e 0 00000000
W 40 deadbeef 2 00000000
W 9c 0badf00d 2 00000000
R 00 00000000 0 11110000
R 01 00000000 0 22220001
R 02 00000000 0 33330002
R 07 00000000 0 44440007
R 10 00000000 0 55550010
R 2a 00000000 0 6666002a
R 3e 00000000 0 7777003e
R 3f 00000000 0 00000000
R 40 00000000 2 00000000
R ff 00000000 2 00000000
W 20 a0a00020 0 00000000
W 21 a1a10021 0 00000000
W 22 a2a20022 0 00000000
W 23 a3a30023 0 00000000
W 24 a4a40024 0 00000000
W 25 a5a50025 0 00000000
W 26 a6a60026 0 00000000
R 20 00000000 0 a0a00020
R 21 00000000 0 a1a10021
R 22 00000000 0 a2a20022
R 23 00000000 0 a3a30023
R 24 00000000 0 a4a40024
R 25 00000000 0 a5a50025
R 26 00000000 0 a6a60026
R 30 00000000 0 00000000

//--- bench/axi_mem_reg_assert.sv
// Concurrent checks on the request FIFOs and the response channels
// Bound into the slave for its FIFOs and response registers, and into the top for its ports
`timescale 1ns/1ns

module axi_mem_reg_assert
#(
    // Only the slave instance sees real FIFO signals
    parameter bit check_fifos = 1'b1
)
(
    input logic mem_slave,
    input logic rst_n,
    input logic [2:0] fifo_push,
    input logic [$clog2(axi_reg_pkg::req_fifo_depth+1)-1:0] count0,
    input logic [$clog2(axi_reg_pkg::req_fifo_depth+1)-1:0] count1,
    input logic [$clog2(axi_reg_pkg::req_fifo_depth+1)-1:0] count2,
    input logic bvalid,
    input logic bready,
    input axi_reg_pkg::resp_t bresp,
    input logic rvalid,
    input logic rready,
    input axi_reg_pkg::data_t rdata,
    input axi_reg_pkg::resp_t rresp
);
    import axi_reg_pkg::*;

    // Count of failed assertions in this instance
    int failures = 0;

    if (check_fifos)
    begin : fifo_room
        // The margin must keep a full FIFO from ever seeing a push
        a_aw_fifo_room: assert property (@(posedge mem_slave) disable iff (!rst_n)
            !(fifo_push[0] && count0 == req_fifo_depth))
            else
            begin
                $error("write address FIFO pushed while full");
                failures++;
            end
        a_w_fifo_room: assert property (@(posedge mem_slave) disable iff (!rst_n)
            !(fifo_push[1] && count1 == req_fifo_depth))
            else
            begin
                $error("write data FIFO pushed while full");
                failures++;
            end
        a_ar_fifo_room: assert property (@(posedge mem_slave) disable iff (!rst_n)
            !(fifo_push[2] && count2 == req_fifo_depth))
            else
            begin
                $error("read address FIFO pushed while full");
                failures++;
            end
    end

    // A stalled response keeps its valid and payload
    a_b_hold: assert property (@(posedge mem_slave) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else
        begin
            $error("write response changed while stalled");
            failures++;
        end
    a_r_hold: assert property (@(posedge mem_slave) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else
        begin
            $error("read response changed while stalled");
            failures++;
        end

    // No response may be offered while reset is applied
    a_reset_quiet: assert property (@(posedge mem_slave) !rst_n |=> !bvalid && !rvalid)
        else
        begin
            $error("response valid high during reset");
            failures++;
        end

endmodule

bind axi_mem_slave axi_mem_reg_assert fifo_checks
(
    .mem_slave(mem_slave),
    .rst_n(rst_n),
    .fifo_push(fifo_push),
    .count0(req_fifo[0].count),
    .count1(req_fifo[1].count),
    .count2(req_fifo[2].count),
    .bvalid(bus.bvalid),
    .bready(bus.bready),
    .bresp(bus.bresp),
    .rvalid(bus.rvalid),
    .rready(bus.rready),
    .rdata(bus.rdata),
    .rresp(bus.rresp)
);

bind axi_mem_reg_top axi_mem_reg_assert #(.check_fifos(1'b0)) port_checks
(
    .mem_slave(mem_slave),
    .rst_n(rst_n),
    .fifo_push(3'b000),
    .count0('0),
    .count1('0),
    .count2('0),
    .bvalid(bvalid),
    .bready(bready),
    .bresp(bresp),
    .rvalid(rvalid),
    .rready(rready),
    .rdata(rdata),
    .rresp(rresp)
);

//--- bench/axi_mem_reg_tb.sv
// Testbench for the AXI register slice with its memory slave
// Replays the golden request list and checks each response in order
`timescale 1ns/1ns

module axi_mem_reg_tb;
    import axi_reg_pkg::*;

    localparam int clk_period = 8;
    localparam int timeout_cycles = 2000;
    localparam logic [31:0] lfsr_seed = 32'h17d635f8;

    logic mem_slave;
    logic rst_n;
    logic awvalid;
    logic awready;
    addr_t awaddr;
    logic wvalid;
    logic wready;
    data_t wdata;
    logic bvalid;
    logic bready;
    resp_t bresp;
    logic arvalid;
    logic arready;
    addr_t araddr;
    logic rvalid;
    logic rready;
    data_t rdata;
    resp_t rresp;

    // Expected responses with one queue per response channel
    resp_t exp_bresp_q [$];
    resp_t exp_rresp_q [$];
    data_t exp_rdata_q [$];

    int value_errors;
    int other_errors;
    logic run_aborted;
    logic readys_up;
    logic ready_dropped;
    logic [31:0] lfsr_state;

    axi_mem_reg_top UUT
    (
        .mem_slave(mem_slave), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    initial
    begin
        mem_slave = 1'b0;
        forever #(clk_period / 2) mem_slave = ~mem_slave;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    // Level is high only when two bits are both set, so stalls dominate.
    // Stretches last 1 to 16 cycles
    task automatic new_stretch(output logic level, output int length);
        logic b0;
        logic b1;
        logic [3:0] len;
        take_bit(b0);
        take_bit(b1);
        level = b0 & b1;
        for (int i = 0; i < 4; i++)
        begin
            take_bit(b0);
            len[i] = b0;
        end
        length = int'(len) + 1;
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value === 1'b0)
        else
        begin
            $display("FAIL t=%0t %s got %b expected 0", $time, name, value);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR t=%0t timeout while waiting for %s", $time, what);
        other_errors++;
        run_aborted = 1'b1;
    endtask

    // ======================================================================
    // Response side with random back-pressure and in-order checks
    // ======================================================================

    initial
    begin : response_side
        logic b_level;
        logic r_level;
        int b_left;
        int r_left;
        resp_t exp_resp;
        data_t exp_data;
        bready = 1'b0;
        rready = 1'b0;
        lfsr_state = lfsr_seed;
        b_left = 0;
        r_left = 0;
        forever
        begin
            @(negedge mem_slave);
            if (b_left == 0)
                new_stretch(b_level, b_left);
            if (r_left == 0)
                new_stretch(r_level, r_left);
            b_left--;
            r_left--;
            bready = b_level;
            rready = r_level;
            if (readys_up && (!awready || !wready || !arready))
                ready_dropped = 1'b1;

            // Valid and ready are both stable here, so the transfer
            // completes at the coming rising edge
            if (rst_n && bvalid && bready)
            begin
                if (exp_bresp_q.size() == 0)
                begin
                    $display("ERROR t=%0t write response with no write outstanding", $time);
                    other_errors++;
                end
                else
                begin
                    exp_resp = exp_bresp_q.pop_front();
                    assert (bresp === exp_resp)
                    else
                    begin
                        $display("FAIL t=%0t bresp got %h expected %h", $time, bresp, exp_resp);
                        value_errors++;
                    end
                end
            end
            if (rst_n && rvalid && rready)
            begin
                if (exp_rresp_q.size() == 0)
                begin
                    $display("ERROR t=%0t read response with no read outstanding", $time);
                    other_errors++;
                end
                else
                begin
                    exp_resp = exp_rresp_q.pop_front();
                    exp_data = exp_rdata_q.pop_front();
                    assert (rresp === exp_resp)
                    else
                    begin
                        $display("FAIL t=%0t rresp got %h expected %h", $time, rresp, exp_resp);
                        value_errors++;
                    end
                    assert (rdata === exp_data)
                    else
                    begin
                        $display("FAIL t=%0t rdata got %h expected %h", $time, rdata, exp_data);
                        value_errors++;
                    end
                end
            end
        end
    end

    // ======================================================================
    // Request side
    // ======================================================================

    // Valid is raised only while ready is high, so every raised valid is
    // accepted at the next rising edge
    task automatic issue_write(input addr_t addr, input data_t data, input resp_t resp);
        logic aw_pending;
        logic w_pending;
        int cycles;
        exp_bresp_q.push_back(resp);
        aw_pending = 1'b1;
        w_pending = 1'b1;
        cycles = 0;
        while ((aw_pending || w_pending) && !run_aborted)
        begin
            @(negedge mem_slave);
            arvalid = 1'b0;
            awvalid = aw_pending && awready;
            wvalid = w_pending && wready;
            if (awvalid)
            begin
                awaddr = addr;
                aw_pending = 1'b0;
            end
            if (wvalid)
            begin
                wdata = data;
                w_pending = 1'b0;
            end
            cycles++;
            if ((aw_pending || w_pending) && cycles >= timeout_cycles)
                report_timeout("write request acceptance");
        end
    endtask

    task automatic issue_read(input addr_t addr, input resp_t resp, input data_t data);
        logic ar_pending;
        int cycles;
        exp_rresp_q.push_back(resp);
        exp_rdata_q.push_back(data);
        ar_pending = 1'b1;
        cycles = 0;
        while (ar_pending && !run_aborted)
        begin
            @(negedge mem_slave);
            awvalid = 1'b0;
            wvalid = 1'b0;
            arvalid = arready;
            if (arvalid)
            begin
                araddr = addr;
                ar_pending = 1'b0;
            end
            cycles++;
            if (ar_pending && cycles >= timeout_cycles)
                report_timeout("read request acceptance");
        end
    endtask

    // Drops all request valids and waits until the chosen channels are idle
    task automatic drain_responses(input logic writes, input logic reads);
        int cycles;
        cycles = 0;
        while (!run_aborted && ((writes && exp_bresp_q.size() != 0)
                                || (reads && exp_rresp_q.size() != 0)))
        begin
            @(negedge mem_slave);
            awvalid = 1'b0;
            wvalid = 1'b0;
            arvalid = 1'b0;
            cycles++;
            if (cycles >= timeout_cycles)
                report_timeout("outstanding responses");
        end
    endtask

    initial
    begin : request_side
        int fd;
        int cycles;
        int fields;
        string line;
        logic [7:0] op;
        addr_t g_addr;
        data_t g_wdata;
        resp_t g_resp;
        data_t g_rdata;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        arvalid = 1'b0;
        araddr = '0;
        rst_n = 1'b0;
        value_errors = 0;
        other_errors = 0;
        run_aborted = 1'b0;
        readys_up = 1'b0;
        ready_dropped = 1'b0;

        // Nothing may be offered or accepted while in reset
        repeat (8)
        begin
            @(negedge mem_slave);
            expect_low("awready", awready);
            expect_low("wready", wready);
            expect_low("arready", arready);
            expect_low("bvalid", bvalid);
            expect_low("rvalid", rvalid);
        end
        rst_n = 1'b1;

        cycles = 0;
        while (!(awready && wready && arready) && !run_aborted)
        begin
            @(negedge mem_slave);
            expect_low("bvalid", bvalid);
            expect_low("rvalid", rvalid);
            cycles++;
            if (cycles >= timeout_cycles)
                report_timeout("request readys after reset");
        end
        readys_up = 1'b1;

        fd = $fopen("bench/axi_mem_golden.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR golden request file could not be opened");
            other_errors++;
            run_aborted = 1'b1;
        end
        while (!run_aborted && $fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%s %h %h %h %h", op, g_addr, g_wdata, g_resp, g_rdata);
                if (fields != 5)
                begin
                    $display("ERROR golden line is malformed: %s", line);
                    other_errors++;
                end
                // Reads wait for all writes to finish and vice versa
                else if (op == "W")
                begin
                    drain_responses(1'b0, 1'b1);
                    issue_write(g_addr, g_wdata, g_resp);
                end
                else if (op == "R")
                begin
                    drain_responses(1'b1, 1'b0);
                    issue_read(g_addr, g_resp, g_rdata);
                end
                else
                begin
                    $display("ERROR golden line has an unknown operation: %s", line);
                    other_errors++;
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        @(negedge mem_slave);
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
        drain_responses(1'b1, 1'b1);

        // Settle so that any extra response shows up
        repeat (20) @(negedge mem_slave);
        if (!run_aborted)
        begin
            assert (ready_dropped)
            else
            begin
                $display("ERROR request readys never fell under back-pressure");
                other_errors++;
            end
        end

        // Failures of the bound concurrent assertions count against the run
        other_errors += UUT.slave.fifo_checks.failures + UUT.port_checks.failures;

        $display("Error summary: %0d value mismatches, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- src/axi_mem_if.sv
// AXI memory-mapped bus with single-beat channels
// The master-side and slave-side views are given as modports
`timescale 1ns/1ns

interface axi_mem_if
(
    input logic mem_slave,
    input logic rst_n
);
    import axi_reg_pkg::*;

    // Write address channel
    logic awvalid;
    logic awready;
    addr_t awaddr;

    // Write data channel
    logic wvalid;
    logic wready;
    data_t wdata;

    // Write response channel
    logic bvalid;
    logic bready;
    resp_t bresp;

    // Read address channel
    logic arvalid;
    logic arready;
    addr_t araddr;

    // Read data channel
    logic rvalid;
    logic rready;
    data_t rdata;
    resp_t rresp;

    // Seen from the requesting side, looking towards a slave
    modport to_slave
    (
        input mem_slave, rst_n,
        output awvalid, awaddr, wvalid, wdata, arvalid, araddr, bready, rready,
        input awready, wready, arready, bvalid, bresp, rvalid, rdata, rresp
    );

    // Seen from the responding side, looking towards a master
    modport to_master
    (
        input mem_slave, rst_n,
        input awvalid, awaddr, wvalid, wdata, arvalid, araddr, bready, rready,
        output awready, wready, arready, bvalid, bresp, rvalid, rdata, rresp
    );

endinterface

//--- src/axi_mem_reg_stages.sv
// AXI register slice between a master-side bus and a slave-side bus
// Requests use an almost-full ready protocol, responses a normal handshake
`timescale 1ns/1ns

module axi_mem_reg_stages
#(
    parameter int n_reg_stages = axi_reg_pkg::n_reg_stages,
    parameter int n_ready_stages = axi_reg_pkg::n_ready_stages
)
(
    input logic mem_slave,
    input logic rst_n,
    axi_mem_if.to_slave slv,
    axi_mem_if.to_master mst
);
    import axi_reg_pkg::*;

    // ======================================================================
    // Request channels, master to slave
    // ======================================================================

    // Index 0 is the master side, index n_reg_stages feeds the slave
    logic aw_valid_pipe [n_reg_stages+1];
    logic w_valid_pipe [n_reg_stages+1];
    logic ar_valid_pipe [n_reg_stages+1];
    addr_t aw_addr_pipe [n_reg_stages+1];
    data_t w_data_pipe [n_reg_stages+1];
    addr_t ar_addr_pipe [n_reg_stages+1];

    // Only accepted requests enter the pipeline.
    // A valid at the slave is then always a real request
    assign aw_valid_pipe[0] = mst.awvalid && mst.awready;
    assign w_valid_pipe[0] = mst.wvalid && mst.wready;
    assign ar_valid_pipe[0] = mst.arvalid && mst.arready;
    assign aw_addr_pipe[0] = mst.awaddr;
    assign w_data_pipe[0] = mst.wdata;
    assign ar_addr_pipe[0] = mst.araddr;

    for (genvar s = 1; s <= n_reg_stages; s++)
    begin : req_stage
        always_ff @(posedge mem_slave)
        begin
            aw_addr_pipe[s] <= aw_addr_pipe[s-1];
            w_data_pipe[s] <= w_data_pipe[s-1];
            ar_addr_pipe[s] <= ar_addr_pipe[s-1];

            if (!rst_n)
            begin
                aw_valid_pipe[s] <= 1'b0;
                w_valid_pipe[s] <= 1'b0;
                ar_valid_pipe[s] <= 1'b0;
            end
            else
            begin
                aw_valid_pipe[s] <= aw_valid_pipe[s-1];
                w_valid_pipe[s] <= w_valid_pipe[s-1];
                ar_valid_pipe[s] <= ar_valid_pipe[s-1];
            end
        end
    end

    assign slv.awvalid = aw_valid_pipe[n_reg_stages];
    assign slv.wvalid = w_valid_pipe[n_reg_stages];
    assign slv.arvalid = ar_valid_pipe[n_reg_stages];
    assign slv.awaddr = aw_addr_pipe[n_reg_stages];
    assign slv.wdata = w_data_pipe[n_reg_stages];
    assign slv.araddr = ar_addr_pipe[n_reg_stages];

    // Ready shift registers. The slave's ready enters at bit 0 and
    // reaches the master n_ready_stages cycles later
    logic [n_ready_stages-1:0] awready_sr;
    logic [n_ready_stages-1:0] wready_sr;
    logic [n_ready_stages-1:0] arready_sr;

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            awready_sr <= '0;
            wready_sr <= '0;
            arready_sr <= '0;
        end
        else
        begin
            // The cast drops the oldest bit off the top
            awready_sr <= n_ready_stages'({awready_sr, slv.awready});
            wready_sr <= n_ready_stages'({wready_sr, slv.wready});
            arready_sr <= n_ready_stages'({arready_sr, slv.arready});
        end
    end

    assign mst.awready = awready_sr[n_ready_stages-1];
    assign mst.wready = wready_sr[n_ready_stages-1];
    assign mst.arready = arready_sr[n_ready_stages-1];

    // ======================================================================
    // Response channels, slave to master
    // ======================================================================

    // Here index 0 is the slave side
    logic b_valid_pipe [n_reg_stages+1];
    logic b_ready_pipe [n_reg_stages+1];
    resp_t b_resp_pipe [n_reg_stages+1];
    logic r_valid_pipe [n_reg_stages+1];
    logic r_ready_pipe [n_reg_stages+1];
    logic [$bits(data_t)+$bits(resp_t)-1:0] r_pay_pipe [n_reg_stages+1];

    assign b_valid_pipe[0] = slv.bvalid;
    assign b_resp_pipe[0] = slv.bresp;
    assign slv.bready = b_ready_pipe[0];
    assign r_valid_pipe[0] = slv.rvalid;
    assign r_pay_pipe[0] = {slv.rdata, slv.rresp};
    assign slv.rready = r_ready_pipe[0];

    for (genvar s = 1; s <= n_reg_stages; s++)
    begin : rsp_stage
        ready_enable_reg #(.n_data_bits($bits(resp_t))) b_reg
        (
            .mem_slave(mem_slave),
            .rst_n(rst_n),
            .enable_from_src(b_valid_pipe[s-1]),
            .data_from_src(b_resp_pipe[s-1]),
            .ready_to_src(b_ready_pipe[s-1]),
            .ready_from_dst(b_ready_pipe[s]),
            .enable_to_dst(b_valid_pipe[s]),
            .data_to_dst(b_resp_pipe[s])
        );

        ready_enable_reg #(.n_data_bits($bits(data_t) + $bits(resp_t))) r_reg
        (
            .mem_slave(mem_slave),
            .rst_n(rst_n),
            .enable_from_src(r_valid_pipe[s-1]),
            .data_from_src(r_pay_pipe[s-1]),
            .ready_to_src(r_ready_pipe[s-1]),
            .ready_from_dst(r_ready_pipe[s]),
            .enable_to_dst(r_valid_pipe[s]),
            .data_to_dst(r_pay_pipe[s])
        );
    end

    assign mst.bvalid = b_valid_pipe[n_reg_stages];
    assign mst.bresp = b_resp_pipe[n_reg_stages];
    assign b_ready_pipe[n_reg_stages] = mst.bready;
    assign mst.rvalid = r_valid_pipe[n_reg_stages];
    assign {mst.rdata, mst.rresp} = r_pay_pipe[n_reg_stages];
    assign r_ready_pipe[n_reg_stages] = mst.rready;

endmodule

//--- src/axi_mem_reg_top.sv
// Top level of the AXI register slice with its memory slave
// Plain AXI ports outside, interface buses between the blocks inside
`timescale 1ns/1ns

module axi_mem_reg_top
(
    input logic mem_slave,
    input logic rst_n,

    // Write address channel
    input logic awvalid,
    output logic awready,
    input axi_reg_pkg::addr_t awaddr,

    // Write data channel
    input logic wvalid,
    output logic wready,
    input axi_reg_pkg::data_t wdata,

    // Write response channel
    output logic bvalid,
    input logic bready,
    output axi_reg_pkg::resp_t bresp,

    // Read address channel
    input logic arvalid,
    output logic arready,
    input axi_reg_pkg::addr_t araddr,

    // Read data channel
    output logic rvalid,
    input logic rready,
    output axi_reg_pkg::data_t rdata,
    output axi_reg_pkg::resp_t rresp
);

    // Bus on the master side of the stages, and bus in front of the slave
    axi_mem_if mst_bus (.mem_slave(mem_slave), .rst_n(rst_n));
    axi_mem_if slv_bus (.mem_slave(mem_slave), .rst_n(rst_n));

    // Map the plain ports onto the master-side bus
    assign mst_bus.awvalid = awvalid;
    assign mst_bus.awaddr = awaddr;
    assign mst_bus.wvalid = wvalid;
    assign mst_bus.wdata = wdata;
    assign mst_bus.arvalid = arvalid;
    assign mst_bus.araddr = araddr;
    assign mst_bus.bready = bready;
    assign mst_bus.rready = rready;
    assign awready = mst_bus.awready;
    assign wready = mst_bus.wready;
    assign arready = mst_bus.arready;
    assign bvalid = mst_bus.bvalid;
    assign bresp = mst_bus.bresp;
    assign rvalid = mst_bus.rvalid;
    assign rdata = mst_bus.rdata;
    assign rresp = mst_bus.rresp;

    axi_mem_reg_stages stages
    (
        .mem_slave(mem_slave),
        .rst_n(rst_n),
        .slv(slv_bus.to_slave),
        .mst(mst_bus.to_master)
    );

    axi_mem_slave slave
    (
        .mem_slave(mem_slave),
        .rst_n(rst_n),
        .bus(slv_bus.to_master)
    );

endmodule

//--- src/axi_mem_slave.sv
// Memory slave behind the AXI register slice
// Request FIFOs with almost-full ready, a word memory and response registers
`timescale 1ns/1ns

module axi_mem_slave
(
    input logic mem_slave,
    input logic rst_n,
    axi_mem_if.to_master bus
);
    import axi_reg_pkg::*;

    // ======================================================================
    // Request FIFOs
    // ======================================================================

    // FIFO 0 holds write addresses, 1 write data and 2 read addresses.
    // Addresses are stored zero-extended to the data width
    logic [2:0] fifo_push;
    logic [2:0] fifo_pop;
    logic [2:0] fifo_has_head;
    logic [2:0] fifo_ready;
    data_t fifo_din [3];
    data_t fifo_dout [3];

    // Every valid arriving here is an accepted request, so it is pushed
    // without regard to the current ready
    assign fifo_push = {bus.arvalid, bus.wvalid, bus.awvalid};
    assign fifo_din[0] = data_t'(bus.awaddr);
    assign fifo_din[1] = bus.wdata;
    assign fifo_din[2] = data_t'(bus.araddr);

    for (genvar f = 0; f < 3; f++)
    begin : req_fifo
        data_t slots [req_fifo_depth];
        logic [$clog2(req_fifo_depth)-1:0] wr_ptr;
        logic [$clog2(req_fifo_depth)-1:0] rd_ptr;
        logic [$clog2(req_fifo_depth+1)-1:0] count;

        // Pointers wrap on their own since the depth is a power of two
        always_ff @(posedge mem_slave)
        begin
            if (!rst_n)
            begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end
            else
            begin
                if (fifo_push[f])
                    wr_ptr <= wr_ptr + 1'b1;
                if (fifo_pop[f])
                    rd_ptr <= rd_ptr + 1'b1;
                case ({fifo_push[f], fifo_pop[f]})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge mem_slave)
        begin
            if (fifo_push[f])
                slots[wr_ptr] <= fifo_din[f];
        end

        assign fifo_dout[f] = slots[rd_ptr];
        assign fifo_has_head[f] = (count != '0);

        // Ready only while free slots exceed the margin for requests in flight
        assign fifo_ready[f] = (int'(count) + ready_margin) < req_fifo_depth;
    end

    assign bus.awready = fifo_ready[0];
    assign bus.wready = fifo_ready[1];
    assign bus.arready = fifo_ready[2];

    // ======================================================================
    // Memory and responses
    // ======================================================================

    data_t mem_array [mem_words];
    addr_t wr_addr;
    addr_t rd_addr;
    logic wr_in_range;
    logic rd_in_range;
    logic do_write;
    logic do_read;

    assign wr_addr = fifo_dout[0][$bits(addr_t)-1:0];
    assign rd_addr = fifo_dout[2][$bits(addr_t)-1:0];
    assign wr_in_range = wr_addr < mem_words;
    assign rd_in_range = rd_addr < mem_words;

    // A write needs both heads, and each needs room in its response register
    assign do_write = fifo_has_head[0] && fifo_has_head[1] && (!bus.bvalid || bus.bready);
    assign do_read = fifo_has_head[2] && (!bus.rvalid || bus.rready);
    assign fifo_pop = {do_read, do_write, do_write};

    // Memory starts out zeroed, so unwritten words read back as zero
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < mem_words; i++)
                mem_array[i] <= '0;
        end
        else if (do_write && wr_in_range)
        begin
            mem_array[wr_addr[$clog2(mem_words)-1:0]] <= fifo_dout[1];
        end
    end

    // Write response register, held until the stage above takes it
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
            bus.bvalid <= 1'b0;
        else if (do_write)
            bus.bvalid <= 1'b1;
        else if (bus.bready)
            bus.bvalid <= 1'b0;

        if (do_write)
            bus.bresp <= wr_in_range ? resp_okay : resp_slverr;
    end

    // Read response register, out-of-range reads return zero
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
            bus.rvalid <= 1'b0;
        else if (do_read)
            bus.rvalid <= 1'b1;
        else if (bus.rready)
            bus.rvalid <= 1'b0;

        if (do_read)
        begin
            bus.rdata <= rd_in_range ? mem_array[rd_addr[$clog2(mem_words)-1:0]] : '0;
            bus.rresp <= rd_in_range ? resp_okay : resp_slverr;
        end
    end

endmodule

//--- src/axi_reg_pkg.sv
// AXI register slice shared definitions
// Payload widths, response codes, stage counts and request FIFO sizing
package axi_reg_pkg;

    // Word address as seen on the bus, wider than the memory needs
    // so that out-of-range requests can be expressed
    typedef logic [7:0] addr_t;

    // One memory word
    typedef logic [31:0] data_t;

    // AXI response code
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // Memory depth in words, any address at or above this is rejected
    localparam int mem_words = 64;

    // Register stages on every channel between master and slave
    localparam int n_reg_stages = 2;

    // Length of the almost-full ready shift registers
    localparam int n_ready_stages = n_reg_stages;

    // Entries in each slave request FIFO
    localparam int req_fifo_depth = 8;

    // Free slots the slave must keep in reserve while ready is high.
    // Covers requests already in the stages, requests accepted while a
    // lowered ready travels back, and one cycle of slack
    localparam int ready_margin = n_reg_stages + n_ready_stages + 1;

endpackage

//--- src/ready_enable_reg.sv
// Single-entry pipeline register with a valid/ready handshake on both sides
// Used for the response channels, where the destination may stall
`timescale 1ns/1ns

module ready_enable_reg
#(
    parameter int n_data_bits = 32
)
(
    input logic mem_slave,
    input logic rst_n,

    // Source side
    input logic enable_from_src,
    input logic [n_data_bits-1:0] data_from_src,
    output logic ready_to_src,

    // Destination side
    input logic ready_from_dst,
    output logic enable_to_dst,
    output logic [n_data_bits-1:0] data_to_dst
);

    // The entry can be refilled when it is empty or is leaving this cycle.
    // Ready to the source is therefore combinational on the destination's ready
    assign ready_to_src = !enable_to_dst || ready_from_dst;

    // Occupancy flag of the single entry
    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            enable_to_dst <= 1'b0;
        end
        else if (ready_to_src)
        begin
            enable_to_dst <= enable_from_src;
        end
    end

    // Payload only moves when the entry is refilled, so it stays steady
    // for as long as the destination stalls
    always_ff @(posedge mem_slave)
    begin
        if (ready_to_src && enable_from_src)
        begin
            data_to_dst <= data_from_src;
        end
    end

endmodule
